// ==== tb.f ====
hdl/udp_video_pkg.sv
hdl/crc32_gen.sv
hdl/ip_checksum.sv
hdl/pixel_fifo.sv
hdl/wb_cfg_regs.sv
hdl/gmii_udp_tx.sv
hdl/video_udp_top.sv
testbench/tb_clk_gen.sv
testbench/tb_frame_checker.sv
testbench/tb_video_udp.sv

// ==== testbench/tb_video_udp.sv ====
`timescale 1ns/1ns

module tb_video_udp;

	import udp_video_pkg::*;

	localparam logic [47:0] SRC_MAC       = 48'h020A_3500_0001;
	localparam logic [47:0] DST_MAC       = 48'h020A_3500_0002;
	localparam logic [31:0] SRC_IP        = 32'hC0A8_0A01;
	localparam int          WORDS_PER_PKT = 8;
	localparam int          FIFO_DEPTH    = 32;

	// Longest frame is YUV, preamble to FCS plus gap and one idle cycle
	localparam int FRAME_CYCLES   = 8 + 42 + 2 + 4 * WORDS_PER_PKT + 4 + IFG_CYCLES + 1;
	localparam int NUM_FRAMES     = 6;
	localparam int SETUP_CYCLES   = 400;
	localparam int TIMEOUT_CYCLES = 2 * (NUM_FRAMES * FRAME_CYCLES + SETUP_CYCLES);

	logic        fifo_clk;
	logic        sys_rst;
	logic        pix_wr;
	logic [47:0] pix_data;
	logic        pix_full;
	logic        wb_cyc;
	logic        wb_stb;
	logic        wb_we;
	logic [1:0]  wb_adr;
	logic [31:0] wb_dat_w;
	logic [31:0] wb_dat_r;
	logic        wb_ack;
	logic [7:0]  txd;
	logic        tx_en;

	int          tb_errors;
	int          frame_errors;
	int          frames_seen;
	int          words_written;
	int          cycles;
	integer      seed;
	logic        cur_rgb;
	logic [31:0] cur_ip;
	logic [31:0] cur_ports;

	tb_clk_gen #(
		.CLK_PERIOD (10),
		.RST_CYCLES (3)
	) u_clk_gen (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst)
	);

	video_udp_top #(
		.SRC_MAC       (SRC_MAC),
		.DST_MAC       (DST_MAC),
		.SRC_IP        (SRC_IP),
		.WORDS_PER_PKT (WORDS_PER_PKT),
		.FIFO_DEPTH    (FIFO_DEPTH)
	) i_video_udp_top (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.pix_wr   (pix_wr),
		.pix_data (pix_data),
		.pix_full (pix_full),
		.wb_cyc   (wb_cyc),
		.wb_stb   (wb_stb),
		.wb_we    (wb_we),
		.wb_adr   (wb_adr),
		.wb_dat_w (wb_dat_w),
		.wb_dat_r (wb_dat_r),
		.wb_ack   (wb_ack),
		.txd      (txd),
		.tx_en    (tx_en)
	);

	tb_frame_checker #(
		.SRC_MAC       (SRC_MAC),
		.DST_MAC       (DST_MAC),
		.SRC_IP        (SRC_IP),
		.WORDS_PER_PKT (WORDS_PER_PKT)
	) u_checker (
		.fifo_clk    (fifo_clk),
		.sys_rst     (sys_rst),
		.txd         (txd),
		.tx_en       (tx_en),
		.error_count (frame_errors),
		.frame_count (frames_seen)
	);

	// ------------------------------------------------------------------
	// Stimulus helpers
	// ------------------------------------------------------------------
	task automatic next_cycle();
		@(posedge fifo_clk);
		#1;
	endtask

	// Classic single transfer, cyc and stb held until ack
	task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
		output logic [31:0] rdata);
		int waited;
		next_cycle();
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdata;
		waited   = 0;
		do begin
			next_cycle();
			waited++;
		end while (!wb_ack && waited < 16);
		if (!wb_ack) begin
			$display("Wishbone access to register %0d was never acknowledged", adr);
			tb_errors++;
		end
		rdata  = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic wb_write(input logic [1:0] adr, input logic [31:0] data);
		logic [31:0] unused;
		wb_access(1'b1, adr, data, unused);
	endtask

	task automatic check_reg(input logic [1:0] adr, input logic [31:0] expected);
		logic [31:0] value;
		wb_access(1'b0, adr, 32'd0, value);
		if (value !== expected) begin
			$display("Fail at %0t ns: register %0d reads %08h, expected %08h",
				$time, adr, value, expected);
			tb_errors++;
		end
	endtask

	task automatic set_config(input logic en, input logic rgb, input logic [31:0] ip,
		input logic [31:0] ports);
		wb_write(REG_DST_IP, ip);
		wb_write(REG_PORTS, ports);
		wb_write(REG_CTRL, {30'd0, rgb, en});
		cur_rgb   = rgb;
		cur_ip    = ip;
		cur_ports = ports;
	endtask

	// Line number follows from the running word count
	task automatic write_words(input int n);
		logic [47:0] word;
		next_cycle();
		for (int i = 0; i < n; i++) begin
			word = {16'(words_written / WORDS_PER_PKT), 32'($random(seed))};
			if (pix_full) begin
				$display("Pixel FIFO was full at %0t ns before a line write", $time);
				tb_errors++;
			end
			pix_wr   = 1'b1;
			pix_data = word;
			u_checker.push_word(word, cur_rgb, cur_ip, cur_ports);
			words_written++;
			next_cycle();
		end
		pix_wr = 1'b0;
	endtask

	task automatic wait_frames(input int n);
		while (frames_seen < n) begin
			@(posedge fifo_clk);
		end
	endtask

	task automatic watch_idle(input int n);
		repeat (n) begin
			next_cycle();
			if (tx_en !== 1'b0) begin
				$display("Fail at %0t ns: tx_en high while no frame may start", $time);
				tb_errors++;
			end
		end
	endtask

	// ------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------
	initial begin
		pix_wr        = 1'b0;
		pix_data      = '0;
		wb_cyc        = 1'b0;
		wb_stb        = 1'b0;
		wb_we         = 1'b0;
		wb_adr        = '0;
		wb_dat_w      = '0;
		tb_errors     = 0;
		words_written = 0;
		seed          = 32'hb53d_707a;
		cur_rgb       = 1'b0;
		cur_ip        = '0;
		cur_ports     = '0;
		@(negedge sys_rst);
		next_cycle();

		// Reset state
		if (tx_en !== 1'b0 || wb_ack !== 1'b0) begin
			$display("Fail at %0t ns: tx_en or wb_ack not low after reset", $time);
			tb_errors++;
		end
		check_reg(REG_STATUS, 32'd0);

		// Register read back, status is read only
		wb_write(REG_CTRL, 32'h0000_0002);
		wb_write(REG_DST_IP, 32'h0A00_0063);
		wb_write(REG_PORTS, 32'h1234_5678);
		check_reg(REG_CTRL, 32'h0000_0002);
		check_reg(REG_DST_IP, 32'h0A00_0063);
		check_reg(REG_PORTS, 32'h1234_5678);
		wb_write(REG_STATUS, 32'hFFFF_FFFF);
		check_reg(REG_STATUS, 32'd0);
		wb_write(REG_CTRL, 32'd0);

		// YUV line
		set_config(1'b1, 1'b0, 32'hC0A8_0A10, {16'd8080, 16'd8081});
		write_words(WORDS_PER_PKT);
		wait_frames(1);

		// RGB line with new addresses
		set_config(1'b1, 1'b1, 32'hC0A8_0B22, {16'd5004, 16'd6000});
		write_words(WORDS_PER_PKT);
		wait_frames(2);

		// Full line held back by enable
		set_config(1'b0, 1'b0, 32'hAC10_0005, {16'd4000, 16'd4001});
		write_words(WORDS_PER_PKT);
		watch_idle(4 * WORDS_PER_PKT);
		wb_write(REG_CTRL, 32'h0000_0001);
		wait_frames(3);

		// Partial line held back until complete
		write_words(WORDS_PER_PKT - 3);
		watch_idle(4 * WORDS_PER_PKT);
		write_words(3);
		wait_frames(4);

		// Two lines back to back
		write_words(2 * WORDS_PER_PKT);
		wait_frames(6);
		repeat (IFG_CYCLES) next_cycle();
		check_reg(REG_STATUS, 32'(frames_seen));
		if (u_checker.pending_words() != 0) begin
			$display("%0d written pixel words were never sent", u_checker.pending_words());
			tb_errors++;
		end

		$display("Closing counts: %0d testbench errors, %0d frame errors, %0d frames checked",
			tb_errors, frame_errors, frames_seen);
		if (tb_errors == 0 && frame_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// Run limit
	initial begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge fifo_clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== testbench/tb_frame_checker.sv ====
`timescale 1ns/1ns

module tb_frame_checker #(
	parameter logic [47:0] SRC_MAC       = 48'h0023_4567_8901,
	parameter logic [47:0] DST_MAC       = 48'h0023_4567_8902,
	parameter logic [31:0] SRC_IP        = 32'hC0A8_0001,
	parameter int          WORDS_PER_PKT = 8
) (
	input  logic       fifo_clk,
	input  logic       sys_rst,
	input  logic [7:0] txd,
	input  logic       tx_en,
	output int         error_count,
	output int         frame_count
);

	import udp_video_pkg::*;

	localparam int MAX_BYTES = 64 + 4 * WORDS_PER_PKT;

	// Words written by the testbench, with the settings in force at the time
	logic [47:0] word_q [$];
	logic        rgb_q [$];
	logic [31:0] ip_q [$];
	logic [31:0] ports_q [$];

	pixel_word_u line_words [WORDS_PER_PKT];
	logic [7:0]  exp_frame [MAX_BYTES];
	logic [7:0]  rx_frame [MAX_BYTES];
	int          rx_len;
	int          idle_cycles;
	logic        in_frame;
	logic        seen_frame;

	task automatic push_word(input logic [47:0] word, input logic rgb, input logic [31:0] ip,
		input logic [31:0] ports);
		word_q.push_back(word);
		rgb_q.push_back(rgb);
		ip_q.push_back(ip);
		ports_q.push_back(ports);
	endtask

	function automatic int pending_words();
		return word_q.size();
	endfunction

	// ------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------
	function automatic void put_bytes(inout int n, input logic [159:0] value, input int count);
		for (int k = 0; k < count; k++) begin
			exp_frame[n] = value[8 * (count - 1 - k) +: 8];
			n++;
		end
	endfunction

	function automatic logic [15:0] header_checksum(input logic [15:0] total_len,
		input logic [31:0] dst);
		logic [31:0] sum;
		sum = IP_VER_TOS + total_len + IP_FLAGS + {IP_TTL, IP_PROTO_UDP};
		sum = sum + SRC_IP[31:16] + SRC_IP[15:0] + dst[31:16] + dst[15:0];
		while (sum[31:16] != 16'd0) begin
			sum = sum[15:0] + sum[31:16];
		end
		return ~sum[15:0];
	endfunction

	// Normal MSB-first CRC fed LSB first, reflected at the end
	function automatic logic [31:0] ethernet_fcs(input int first, input int last);
		logic [31:0] state;
		logic [31:0] fcs;
		logic        fb;
		state = '1;
		for (int n = first; n < last; n++) begin
			for (int b = 0; b < 8; b++) begin
				fb    = exp_frame[n][b] ^ state[31];
				state = {state[30:0], 1'b0};
				if (fb) begin
					state = state ^ 32'h04C1_1DB7;
				end
			end
		end
		for (int b = 0; b < 32; b++) begin
			fcs[b] = ~state[31 - b];
		end
		return fcs;
	endfunction

	function automatic int build_frame(input logic rgb, input logic [31:0] dst,
		input logic [31:0] ports);
		int          n;
		int          pay_len;
		logic [15:0] udp_len;
		logic [15:0] ip_len;
		logic [31:0] fcs;
		n       = 0;
		pay_len = rgb ? 3 * WORDS_PER_PKT : 4 * WORDS_PER_PKT;
		udp_len = 16'(8 + 2 + pay_len);
		ip_len  = 16'd20 + udp_len;
		for (int k = 0; k < 7; k++) begin
			put_bytes(n, PREAMBLE_BYTE, 1);
		end
		put_bytes(n, SFD_BYTE, 1);
		put_bytes(n, {DST_MAC, SRC_MAC, ETH_TYPE_IPV4}, 14);
		put_bytes(n, {IP_VER_TOS, ip_len, 16'h0000, IP_FLAGS}, 8);
		put_bytes(n, {IP_TTL, IP_PROTO_UDP, header_checksum(ip_len, dst)}, 4);
		put_bytes(n, {SRC_IP, dst}, 8);
		put_bytes(n, {ports, udp_len, 16'h0000}, 8);
		put_bytes(n, line_words[0].yuv.line, 2);
		for (int w = 0; w < WORDS_PER_PKT; w++) begin
			if (rgb) begin
				put_bytes(n, {line_words[w].rgb.r, line_words[w].rgb.g, line_words[w].rgb.b}, 3);
			end else begin
				put_bytes(n, {line_words[w].yuv.y0, line_words[w].yuv.cb,
					line_words[w].yuv.y1, line_words[w].yuv.cr}, 4);
			end
		end
		// FCS covers destination MAC to end of payload
		fcs = ethernet_fcs(8, n);
		for (int k = 0; k < 4; k++) begin
			put_bytes(n, fcs[8 * k +: 8], 1);
		end
		return n;
	endfunction

	// ------------------------------------------------------------------
	// Comparison
	// ------------------------------------------------------------------
	task automatic check_frame();
		logic        rgb;
		logic [31:0] ip;
		logic [31:0] ports;
		int          exp_len;
		int          n_cmp;
		if (word_q.size() < WORDS_PER_PKT) begin
			$display("Frame %0d at %0t ns was sent while no complete line was written",
				frame_count, $time);
			error_count++;
		end else begin
			rgb   = rgb_q[0];
			ip    = ip_q[0];
			ports = ports_q[0];
			for (int w = 0; w < WORDS_PER_PKT; w++) begin
				line_words[w] = word_q.pop_front();
				void'(rgb_q.pop_front());
				void'(ip_q.pop_front());
				void'(ports_q.pop_front());
			end
			exp_len = build_frame(rgb, ip, ports);
			if (rx_len != exp_len) begin
				$display("Fail at %0t ns: frame %0d has %0d bytes, expected %0d",
					$time, frame_count, rx_len, exp_len);
				error_count++;
			end
			n_cmp = (rx_len < exp_len) ? rx_len : exp_len;
			for (int k = 0; k < n_cmp; k++) begin
				if (rx_frame[k] !== exp_frame[k]) begin
					$display("Fail at %0t ns: frame %0d byte %0d is %02h, expected %02h",
						$time, frame_count, k, rx_frame[k], exp_frame[k]);
					error_count++;
				end
			end
		end
	endtask

	// Sampled on the falling edge, away from the DUT's updates
	always @(negedge fifo_clk) begin
		if (sys_rst) begin
			in_frame    = 1'b0;
			seen_frame  = 1'b0;
			rx_len      = 0;
			idle_cycles = 0;
			error_count = 0;
			frame_count = 0;
		end else if (tx_en) begin
			if (!in_frame) begin
				if (seen_frame && idle_cycles < IFG_CYCLES) begin
					$display("Fail at %0t ns: only %0d idle cycles before frame %0d",
						$time, idle_cycles, frame_count + 1);
					error_count++;
				end
				in_frame = 1'b1;
				rx_len   = 0;
			end
			if (rx_len < MAX_BYTES) begin
				rx_frame[rx_len] = txd;
			end
			rx_len++;
		end else begin
			if (in_frame) begin
				in_frame    = 1'b0;
				seen_frame  = 1'b1;
				idle_cycles = 0;
				frame_count++;
				check_frame();
			end
			idle_cycles++;
		end
	end

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ns

module tb_clk_gen #(
	parameter int CLK_PERIOD = 10,
	parameter int RST_CYCLES = 3
) (
	output logic fifo_clk,
	output logic sys_rst
);

	initial begin
		fifo_clk = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) fifo_clk = ~fifo_clk;
		end
	end

	// Release reset just after an edge, like the other stimulus
	initial begin
		sys_rst = 1'b1;
		repeat (RST_CYCLES) @(posedge fifo_clk);
		#1;
		sys_rst = 1'b0;
	end

endmodule

// ==== hdl/video_udp_top.sv ====
`timescale 1ns/1ns

module video_udp_top #(
	parameter logic [47:0] SRC_MAC       = 48'h0023_4567_8901,
	parameter logic [47:0] DST_MAC       = 48'h0023_4567_8902,
	parameter logic [31:0] SRC_IP        = 32'hC0A8_0001,
	parameter int          WORDS_PER_PKT = 8,
	parameter int          FIFO_DEPTH    = 32
) (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        pix_wr,
	input  logic [47:0] pix_data,
	output logic        pix_full,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [1:0]  wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic        wb_ack,
	output logic [7:0]  txd,
	output logic        tx_en
);

	import udp_video_pkg::*;

	pixel_word_u fifo_head;
	logic [15:0] fifo_count;
	logic        fifo_rd_en;
	logic        tx_enable;
	logic        rgb_mode;
	logic [31:0] dst_ip;
	logic [31:0] udp_ports;
	logic        frame_done;

	pixel_fifo #(
		.FIFO_DEPTH    (FIFO_DEPTH),
		.WORDS_PER_PKT (WORDS_PER_PKT)
	) i_pixel_fifo (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.wr       (pix_wr),
		.wr_data  (pix_data),
		.full     (pix_full),
		.rd_en    (fifo_rd_en),
		.rd_data  (fifo_head),
		.count    (fifo_count)
	);

	wb_cfg_regs i_wb_cfg_regs (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.wb_cyc     (wb_cyc),
		.wb_stb     (wb_stb),
		.wb_we      (wb_we),
		.wb_adr     (wb_adr),
		.wb_dat_w   (wb_dat_w),
		.wb_dat_r   (wb_dat_r),
		.wb_ack     (wb_ack),
		.frame_done (frame_done),
		.tx_enable  (tx_enable),
		.rgb_mode   (rgb_mode),
		.dst_ip     (dst_ip),
		.udp_ports  (udp_ports)
	);

	gmii_udp_tx #(
		.SRC_MAC       (SRC_MAC),
		.DST_MAC       (DST_MAC),
		.SRC_IP        (SRC_IP),
		.WORDS_PER_PKT (WORDS_PER_PKT)
	) i_gmii_udp_tx (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.fifo_data  (fifo_head),
		.fifo_count (fifo_count),
		.fifo_rd_en (fifo_rd_en),
		.tx_enable  (tx_enable),
		.rgb_mode   (rgb_mode),
		.dst_ip     (dst_ip),
		.udp_ports  (udp_ports),
		.frame_done (frame_done),
		.txd        (txd),
		.tx_en      (tx_en)
	);

endmodule

// ==== hdl/gmii_udp_tx.sv ====
`timescale 1ns/1ns

module gmii_udp_tx #(
	parameter logic [47:0] SRC_MAC       = 48'h0023_4567_8901,
	parameter logic [47:0] DST_MAC       = 48'h0023_4567_8902,
	parameter logic [31:0] SRC_IP        = 32'hC0A8_0001,
	parameter int          WORDS_PER_PKT = 8
) (
	input  logic                       fifo_clk,
	input  logic                       sys_rst,
	input  udp_video_pkg::pixel_word_u fifo_data,
	input  logic [15:0]                fifo_count,
	output logic                       fifo_rd_en,
	input  logic                       tx_enable,
	input  logic                       rgb_mode,
	input  logic [31:0]                dst_ip,
	input  logic [31:0]                udp_ports,
	output logic                       frame_done,
	output logic [7:0]                 txd,
	output logic                       tx_en
);

	import udp_video_pkg::*;

	localparam logic [3:0] S_IDLE = 4'd0;
	localparam logic [3:0] S_PRE  = 4'd1;
	localparam logic [3:0] S_SFD  = 4'd2;
	localparam logic [3:0] S_ETH  = 4'd3;
	localparam logic [3:0] S_IP   = 4'd4;
	localparam logic [3:0] S_UDP  = 4'd5;
	localparam logic [3:0] S_LINE = 4'd6;
	localparam logic [3:0] S_PAY  = 4'd7;
	localparam logic [3:0] S_FCS  = 4'd8;
	localparam logic [3:0] S_GAP  = 4'd9;

	localparam logic [15:0] PAY_YUV = 16'(4 * WORDS_PER_PKT);
	localparam logic [15:0] PAY_RGB = 16'(3 * WORDS_PER_PKT);

	logic [3:0]   state;
	logic [7:0]   cnt;
	logic [1:0]   sub;
	logic [15:0]  word_cnt;
	logic         mode_q;
	logic [31:0]  dst_ip_q;
	logic [31:0]  ports_q;
	logic         go;
	logic         word_end;
	logic         last_word;
	logic [7:0]   cur_byte;
	logic [7:0]   pix_byte;
	logic         crc_feed;
	logic [31:0]  crc;
	logic         csum_start;
	logic         csum_done;
	logic [15:0]  csum;
	logic [15:0]  udp_len;
	logic [15:0]  ip_len;
	logic [111:0] eth_hdr;
	logic [159:0] ip_hdr;
	logic [63:0]  udp_hdr;

	assign go        = tx_enable && (fifo_count >= 16'(WORDS_PER_PKT));
	assign word_end  = (sub == (mode_q ? 2'd2 : 2'd3));
	assign last_word = (word_cnt == 16'(WORDS_PER_PKT - 1));
	// Pop the head once its last byte has been taken
	assign fifo_rd_en = (state == S_PAY) && word_end;

	// Line number field counts toward the UDP payload
	assign udp_len = 16'd10 + (mode_q ? PAY_RGB : PAY_YUV);
	assign ip_len  = 16'd20 + udp_len;

	assign eth_hdr = {DST_MAC, SRC_MAC, ETH_TYPE_IPV4};
	assign ip_hdr  = {IP_VER_TOS, ip_len, 16'h0000, IP_FLAGS, IP_TTL, IP_PROTO_UDP,
		csum, SRC_IP, dst_ip_q};
	// UDP checksum left at zero
	assign udp_hdr = {ports_q, udp_len, 16'h0000};

	always_comb begin
		if (mode_q) begin
			case (sub)
				2'd0:    pix_byte = fifo_data.rgb.r;
				2'd1:    pix_byte = fifo_data.rgb.g;
				default: pix_byte = fifo_data.rgb.b;
			endcase
		end else begin
			case (sub)
				2'd0:    pix_byte = fifo_data.yuv.y0;
				2'd1:    pix_byte = fifo_data.yuv.cb;
				2'd2:    pix_byte = fifo_data.yuv.y1;
				default: pix_byte = fifo_data.yuv.cr;
			endcase
		end
	end

	// Byte that goes onto txd at the next edge
	always_comb begin
		case (state)
			S_SFD:   cur_byte = SFD_BYTE;
			S_ETH:   cur_byte = eth_hdr[111 - 8 * cnt -: 8];
			S_IP:    cur_byte = ip_hdr[159 - 8 * cnt -: 8];
			S_UDP:   cur_byte = udp_hdr[63 - 8 * cnt -: 8];
			S_LINE:  cur_byte = cnt[0] ? fifo_data.yuv.line[7:0] : fifo_data.yuv.line[15:8];
			S_PAY:   cur_byte = pix_byte;
			S_FCS:   cur_byte = crc[8 * cnt +: 8];
			S_GAP:   cur_byte = 8'h00;
			default: cur_byte = PREAMBLE_BYTE;
		endcase
	end

	assign crc_feed = (state == S_ETH) || (state == S_IP) || (state == S_UDP) ||
		(state == S_LINE) || (state == S_PAY);

	// ----------------------------------------------------------------------
	// Frame sequencer
	// ----------------------------------------------------------------------
	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state      <= S_IDLE;
			cnt        <= '0;
			sub        <= '0;
			word_cnt   <= '0;
			txd        <= '0;
			tx_en      <= 1'b0;
			csum_start <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			csum_start <= 1'b0;
			frame_done <= 1'b0;
			cnt        <= cnt + 8'd1;
			txd        <= cur_byte;
			tx_en      <= 1'b1;
			case (state)
				S_IDLE: begin
					// First preamble byte leaves straight from idle
					txd        <= go ? cur_byte : 8'h00;
					tx_en      <= go;
					cnt        <= 8'd1;
					csum_start <= go;
					if (go) begin
						state <= S_PRE;
					end
				end
				S_PRE: begin
					if (cnt == 8'd6) begin
						state <= S_SFD;
					end
				end
				S_SFD: begin
					state <= S_ETH;
					cnt   <= '0;
				end
				S_ETH: begin
					if (cnt == 8'd13) begin
						state <= S_IP;
						cnt   <= '0;
					end
				end
				S_IP: begin
					if (cnt == 8'd19) begin
						state <= S_UDP;
						cnt   <= '0;
					end
				end
				S_UDP: begin
					if (cnt == 8'd7) begin
						state <= S_LINE;
						cnt   <= '0;
					end
				end
				S_LINE: begin
					sub      <= '0;
					word_cnt <= '0;
					if (cnt == 8'd1) begin
						state <= S_PAY;
					end
				end
				S_PAY: begin
					sub <= word_end ? 2'd0 : sub + 2'd1;
					cnt <= '0;
					if (word_end) begin
						word_cnt <= word_cnt + 16'd1;
						if (last_word) begin
							state <= S_FCS;
						end
					end
				end
				S_FCS: begin
					if (cnt == 8'd3) begin
						state <= S_GAP;
						cnt   <= '0;
					end
				end
				default: begin
					txd        <= 8'h00;
					tx_en      <= 1'b0;
					frame_done <= (cnt == 8'd0);
					if (cnt == 8'(IFG_CYCLES - 1)) begin
						state <= S_IDLE;
					end
				end
			endcase
		end
	end

	// Settings are frozen for the length of one frame
	always_ff @(posedge fifo_clk) begin
		if (state == S_IDLE && go) begin
			mode_q   <= rgb_mode;
			dst_ip_q <= dst_ip;
			ports_q  <= udp_ports;
		end
	end

	crc32_gen i_crc32_gen (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.init     (state == S_SFD),
		.data_en  (crc_feed),
		.data     (cur_byte),
		.crc      (crc)
	);

	ip_checksum #(
		.SRC_IP (SRC_IP)
	) i_ip_checksum (
		.fifo_clk  (fifo_clk),
		.sys_rst   (sys_rst),
		.start     (csum_start),
		.total_len (ip_len),
		.dst_ip    (dst_ip_q),
		.checksum  (csum),
		.done      (csum_done)
	);

	// Sum must be finished before its high byte is loaded
	assert property (@(posedge fifo_clk) disable iff (sys_rst)
		(state == S_IP && cnt == 8'd10) |-> csum_done);

	// No holes in tx_en between preamble and the end of the FCS
	assert property (@(posedge fifo_clk) disable iff (sys_rst)
		$rose(tx_en) |-> (tx_en until frame_done));

endmodule

// ==== hdl/wb_cfg_regs.sv ====
`timescale 1ns/1ns

module wb_cfg_regs (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        wb_cyc,
	input  logic        wb_stb,
	input  logic        wb_we,
	input  logic [1:0]  wb_adr,
	input  logic [31:0] wb_dat_w,
	output logic [31:0] wb_dat_r,
	output logic        wb_ack,
	input  logic        frame_done,
	output logic        tx_enable,
	output logic        rgb_mode,
	output logic [31:0] dst_ip,
	output logic [31:0] udp_ports
);

	import udp_video_pkg::*;

	logic [1:0]  ctrl_q;
	logic [31:0] dst_ip_q;
	logic [31:0] ports_q;
	logic [31:0] frame_cnt;
	logic [31:0] rd_mux;
	logic        req;
	logic        served;
	logic        ack_set;

	assign req     = wb_cyc && wb_stb;
	// One ack per strobe, then wait for the master to drop it
	assign ack_set = req && !wb_ack && !served;

	always_comb begin
		case (wb_adr)
			REG_CTRL:   rd_mux = {30'd0, ctrl_q};
			REG_DST_IP: rd_mux = dst_ip_q;
			REG_PORTS:  rd_mux = ports_q;
			default:    rd_mux = frame_cnt;
		endcase
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			wb_ack    <= 1'b0;
			served    <= 1'b0;
			wb_dat_r  <= '0;
			ctrl_q    <= '0;
			dst_ip_q  <= '0;
			ports_q   <= '0;
			frame_cnt <= '0;
		end else begin
			wb_ack <= ack_set;
			served <= req && (served || wb_ack);
			if (frame_done) begin
				frame_cnt <= frame_cnt + 32'd1;
			end
			if (ack_set) begin
				wb_dat_r <= rd_mux;
				if (wb_we) begin
					case (wb_adr)
						REG_CTRL:   ctrl_q   <= wb_dat_w[1:0];
						REG_DST_IP: dst_ip_q <= wb_dat_w;
						REG_PORTS:  ports_q  <= wb_dat_w;
						// Status is read only
						default: ;
					endcase
				end
			end
		end
	end

	assign tx_enable = ctrl_q[0];
	assign rgb_mode  = ctrl_q[1];
	assign dst_ip    = dst_ip_q;
	assign udp_ports = ports_q;

	// No second ack while the master keeps the same strobe up
	assert property (@(posedge fifo_clk) disable iff (sys_rst)
		(wb_ack && req) |=> (!wb_ack until !req));

endmodule

// ==== hdl/pixel_fifo.sv ====
`timescale 1ns/1ns

module pixel_fifo #(
	parameter int FIFO_DEPTH    = 32,
	parameter int WORDS_PER_PKT = 8
) (
	input  logic                       fifo_clk,
	input  logic                       sys_rst,
	input  logic                       wr,
	input  udp_video_pkg::pixel_word_u wr_data,
	output logic                       full,
	input  logic                       rd_en,
	output udp_video_pkg::pixel_word_u rd_data,
	output logic [15:0]                count
);

	import udp_video_pkg::*;

	localparam int               PTR_W    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);

	pixel_word_u      mem [FIFO_DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic             do_wr;
	logic             do_rd;

	// A whole line has to fit before a frame can start
	if (FIFO_DEPTH < WORDS_PER_PKT) begin : g_depth_check
		$error("pixel_fifo depth %0d below line length %0d", FIFO_DEPTH, WORDS_PER_PKT);
	end

	assign full    = (count == 16'(FIFO_DEPTH));
	assign do_wr   = wr && !full;
	assign do_rd   = rd_en && (count != 16'd0);
	// First word fall through
	assign rd_data = mem[rd_ptr];

	always_ff @(posedge fifo_clk) begin
		if (do_wr) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) begin
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			end
			if (do_rd) begin
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			end
			case ({do_wr, do_rd})
				2'b10:   count <= count + 16'd1;
				2'b01:   count <= count - 16'd1;
				default: count <= count;
			endcase
		end
	end

	assert property (@(posedge fifo_clk) disable iff (sys_rst) wr |-> !full);
	assert property (@(posedge fifo_clk) disable iff (sys_rst) rd_en |-> (count != 16'd0));

endmodule

// ==== hdl/ip_checksum.sv ====
`timescale 1ns/1ns

module ip_checksum #(
	parameter logic [31:0] SRC_IP = 32'hC0A8_0001
) (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        start,
	input  logic [15:0] total_len,
	input  logic [31:0] dst_ip,
	output logic [15:0] checksum,
	output logic        done
);

	import udp_video_pkg::*;

	logic [15:0] len_q;
	logic [31:0] dst_q;
	logic [19:0] acc;
	logic [3:0]  idx;
	logic        busy;
	logic [15:0] hdr_word;
	logic [16:0] fold1;
	logic [15:0] fold2;

	// Header word for the current step
	always_comb begin
		case (idx)
			4'd0: hdr_word = IP_VER_TOS;
			4'd1: hdr_word = len_q;
			4'd3: hdr_word = IP_FLAGS;
			4'd4: hdr_word = {IP_TTL, IP_PROTO_UDP};
			4'd6: hdr_word = SRC_IP[31:16];
			4'd7: hdr_word = SRC_IP[15:0];
			4'd8: hdr_word = dst_q[31:16];
			4'd9: hdr_word = dst_q[15:0];
			// Identification and checksum field count as zero
			default: hdr_word = 16'h0000;
		endcase
	end

	// Two folds are enough for ten words
	assign fold1 = {1'b0, acc[15:0]} + {13'd0, acc[19:16]};
	assign fold2 = fold1[15:0] + {15'd0, fold1[16]};

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			idx  <= '0;
		end else if (start) begin
			busy <= 1'b1;
			done <= 1'b0;
			idx  <= '0;
		end else if (busy) begin
			idx <= idx + 4'd1;
			if (idx == 4'd10) begin
				busy <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (start) begin
			len_q <= total_len;
			dst_q <= dst_ip;
			acc   <= '0;
		end else if (busy && idx != 4'd10) begin
			acc <= acc + {4'd0, hdr_word};
		end else if (busy) begin
			checksum <= ~fold2;
		end
	end

	// Frame builder may only restart after the previous sum is out
	assert property (@(posedge fifo_clk) disable iff (sys_rst) start |-> !busy);

endmodule

// ==== hdl/crc32_gen.sv ====
`timescale 1ns/1ns

module crc32_gen (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        init,
	input  logic        data_en,
	input  logic [7:0]  data,
	output logic [31:0] crc
);

	// 0x04C11DB7 bit reversed
	localparam logic [31:0] POLY_REFL = 32'hEDB8_8320;

	logic [31:0] crc_q;
	logic [31:0] crc_next;

	// Eight serial steps per byte, LSB first as on the wire
	always_comb begin
		crc_next = crc_q ^ {24'd0, data};
		for (int i = 0; i < 8; i++) begin
			crc_next = crc_next[0] ? ((crc_next >> 1) ^ POLY_REFL) : (crc_next >> 1);
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			crc_q <= '1;
		end else if (init) begin
			crc_q <= '1;
		end else if (data_en) begin
			crc_q <= crc_next;
		end
	end

	// Final complement, byte 0 goes out first
	assign crc = ~crc_q;

endmodule

// ==== hdl/udp_video_pkg.sv ====
package udp_video_pkg;

	// ----------------------------------------------------------------------
	// Ethernet, IPv4 and UDP header constants
	// ----------------------------------------------------------------------
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
	// Version 4, IHL 5, TOS 0
	localparam logic [15:0] IP_VER_TOS    = 16'h4500;
	// Don't fragment
	localparam logic [15:0] IP_FLAGS      = 16'h4000;
	localparam logic [7:0]  IP_TTL        = 8'd64;
	localparam logic [7:0]  IP_PROTO_UDP  = 8'd17;
	localparam logic [7:0]  PREAMBLE_BYTE = 8'h55;
	localparam logic [7:0]  SFD_BYTE      = 8'hD5;
	localparam int          IFG_CYCLES    = 12;

	// ----------------------------------------------------------------------
	// Configuration register map (word index)
	// ----------------------------------------------------------------------
	localparam logic [1:0] REG_CTRL   = 2'd0;
	localparam logic [1:0] REG_DST_IP = 2'd1;
	localparam logic [1:0] REG_PORTS  = 2'd2;
	localparam logic [1:0] REG_STATUS = 2'd3;

	// ----------------------------------------------------------------------
	// Pixel FIFO word, read as YUV422 or as RGB depending on the frame mode
	// ----------------------------------------------------------------------
	typedef union packed {
		struct packed {
			logic [15:0] line;
			logic [7:0]  y0;
			logic [7:0]  cb;
			logic [7:0]  y1;
			logic [7:0]  cr;
		} yuv;
		struct packed {
			logic [15:0] line;
			logic [7:0]  r;
			logic [7:0]  g;
			logic [7:0]  b;
			logic [7:0]  unused;
		} rgb;
	} pixel_word_u;

endpackage
